// File: sim.f
verilog/periph_map_pkg.sv
verilog/bus_pkg.sv
verilog/periph_addr_decode.sv
verilog/gpio_regs.sv
verilog/pin_out_mux.sv
verilog/read_data_capture.sv
verilog/peripheral_fabric.sv
verif/tb_peripheral_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_peripheral_fabric \
    -Mdir obj_dir -f sim.f > build.log 2>&1 \
    && ./obj_dir/Vtb_peripheral_fabric > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/tb_peripheral_fabric.sv
module tb_peripheral_fabric;
    timeunit 1ns;
    timeprecision 1ps;

    import bus_pkg::*;
    import periph_map_pkg::*;

    localparam int TIMEOUT = 20;

    logic                        clk;
    logic                        rst_n;
    bus_req_t                    req;
    byte_t                       ui_in;
    logic                        read_complete;
    word_t [N_USER_SLOTS-1:0]    user_data;
    logic  [N_USER_SLOTS-1:0]    user_ready;
    byte_t [N_SIMPLE_SLOTS-1:0]  simple_data;
    byte_t [N_USER_SLOTS-1:0]    user_uo;
    byte_t [N_SIMPLE_SLOTS-1:0]  simple_uo;
    byte_t                       uo_out;
    word_t                       data_out;
    logic                        data_ready;
    user_onehot_t                user_sel;
    simple_onehot_t              simple_write;
    access_n_t                   peri_read_n;

    integer seed;
    int     n_checks;
    int     n_mismatch;
    int     n_timeout;

    // Reference copy of the GPIO registers
    byte_t                  m_gpio_out;
    func_sel_t [N_PINS-1:0] m_fsel;

    peripheral_fabric dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_ui_in         (ui_in),
        .i_read_complete (read_complete),
        .o_data_out      (data_out),
        .o_data_ready    (data_ready),
        .i_user_data     (user_data),
        .i_user_ready    (user_ready),
        .i_simple_data   (simple_data),
        .i_user_uo       (user_uo),
        .i_simple_uo     (simple_uo),
        .o_user_sel      (user_sel),
        .o_simple_write  (simple_write),
        .o_peri_read_n   (peri_read_n),
        .o_uo_out        (uo_out)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // One of the three real access sizes
    function automatic access_n_t rand_code();
        logic [31:0] r;
        r = rand32() % 32'd3;
        return r[1:0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeout++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // Address map rules
    function automatic void map_addr(input periph_addr_t a, output logic simple,
                                     output int slot);
        simple = 1'b0;
        if (a[10:9] == 2'b10) begin
            simple = 1'b1;
            slot   = int'(a[7:4]);
        end else if (a[10]) begin
            slot = 16 + int'(a[8:6]);
        end else begin
            slot = int'(a[9:6]);
        end
    endfunction

    function automatic periph_addr_t user_addr(input int slot, input logic [5:0] ofs);
        logic [4:0] s;
        s = slot[4:0];
        if (slot < 16) begin
            return {1'b0, s[3:0], ofs};
        end
        return {2'b11, s[2:0], ofs};
    endfunction

    function automatic logic [5:0] fsel_ofs(input int pin);
        logic [2:0] p;
        p = pin[2:0];
        return {1'b1, p, 2'b00};
    endfunction

    task automatic model_write(input periph_addr_t a, input word_t wd);
        logic simple;
        int   slot;
        map_addr(a, simple, slot);
        if (!simple && slot == int'(SLOT_GPIO)) begin
            if (a[5:0] == GPIO_OUT_OFS) begin
                m_gpio_out = wd[7:0];
            end
            for (int p = 0; p < N_PINS; p++) begin
                if (a[5:0] == fsel_ofs(p)) begin
                    m_fsel[p] = wd[5:0];
                end
            end
        end
    endtask

    function automatic word_t model_read(input periph_addr_t a);
        logic  simple;
        int    slot;
        word_t r;
        map_addr(a, simple, slot);
        r = '0;
        if (simple) begin
            r = {24'h0, simple_data[slot]};
        end else if (slot == int'(SLOT_GPIO)) begin
            if (a[5:0] == GPIO_OUT_OFS) begin
                r = {24'h0, m_gpio_out};
            end else if (a[5:0] == GPIO_IN_OFS) begin
                r = {24'h0, ui_in};
            end
            for (int p = 0; p < N_PINS; p++) begin
                if (a[5:0] == fsel_ofs(p)) begin
                    r = {26'h0, m_fsel[p]};
                end
            end
        end else if (slot != 0) begin
            r = user_data[slot];
        end
        return r;
    endfunction

    // Expected pins from the function selects
    function automatic byte_t model_pins();
        byte_t     r;
        func_sel_t fs;
        int        u;
        r = '0;
        for (int p = 0; p < N_PINS; p++) begin
            fs = m_fsel[p];
            u  = int'({fs[5], fs[3:0]});
            if (fs[4]) begin
                r[p] = simple_uo[fs[3:0]][p];
            end else if (u == int'(SLOT_GPIO)) begin
                r[p] = m_gpio_out[p];
            end else if (u > 0 && u < N_USER_SLOTS) begin
                r[p] = user_uo[u][p];
            end
        end
        return r;
    endfunction

    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_ready && cycles < TIMEOUT);
        if (!data_ready) begin
            report_timeout("o_data_ready never rose after a read");
        end
    endtask

    task automatic release_read();
        req.read_n    = ACCESS_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    // Write cycle with strobe and ready checks
    task automatic bus_write(input periph_addr_t a, input word_t wd);
        logic simple;
        int   slot;
        map_addr(a, simple, slot);
        @(negedge clk);
        req.addr    = a;
        req.wdata   = wd;
        req.write_n = rand_code();
        req.read_n  = ACCESS_NONE;
        #1;
        check("o_data_ready", 32'(data_ready), 32'd1);
        if (simple) begin
            check("o_simple_write", 32'(simple_write), 32'd1 << slot);
            check("o_user_sel", 32'(user_sel), 32'd0);
        end else begin
            check("o_user_sel", 32'(user_sel), 32'd1 << slot);
            check("o_simple_write", 32'(simple_write), 32'd0);
        end
        model_write(a, wd);
        @(negedge clk);
        req.write_n = ACCESS_NONE;
    endtask

    // Read from a slot that is always ready
    task automatic read_check(input periph_addr_t a);
        word_t exp;
        int    n;
        exp = model_read(a);
        @(negedge clk);
        req.addr   = a;
        req.read_n = rand_code();
        wait_ready(n);
        check("read latency", 32'(n), 32'd1);
        check("o_data_out", data_out, exp);
        check("o_peri_read_n", 32'(peri_read_n), 32'(ACCESS_NONE));
        release_read();
    endtask

    // Read from an external user slot that holds off, then changes its data
    task automatic stalled_read(input int slot);
        logic [31:0]  r;
        periph_addr_t a;
        word_t        exp;
        int           n;
        r = rand32();
        a = user_addr(slot, r[5:0]);
        @(negedge clk);
        user_ready[slot] = 1'b0;
        user_data[slot]  = rand32();
        req.addr         = a;
        req.read_n       = rand_code();
        repeat (int'(r[9:8]) + 1) begin
            @(negedge clk);
            check("o_data_ready", 32'(data_ready), 32'd0);
            check("o_peri_read_n", 32'(peri_read_n), 32'(req.read_n));
        end
        exp = model_read(a);
        user_ready[slot] = 1'b1;
        wait_ready(n);
        check("read latency", 32'(n), 32'd1);
        check("o_data_out", data_out, exp);
        user_data[slot] = ~exp;
        repeat (2) begin
            @(negedge clk);
            check("o_data_out", data_out, exp);
            check("o_peri_read_n", 32'(peri_read_n), 32'(ACCESS_NONE));
        end
        // Read complete while the read is still ready takes the new data
        exp           = model_read(a);
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        check("o_data_out", data_out, exp);
        release_read();
        user_ready[slot] = r[12];
    endtask

    initial begin
        logic [31:0] r;
        seed          = 32'hacc;
        n_checks      = 0;
        n_mismatch    = 0;
        n_timeout     = 0;
        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = '0;
        req.write_n   = ACCESS_NONE;
        req.read_n    = ACCESS_NONE;
        ui_in         = '0;
        read_complete = 1'b0;
        for (int s = 0; s < N_USER_SLOTS; s++) begin
            r             = rand32();
            user_data[s]  = rand32();
            user_ready[s] = r[8];
            user_uo[s]    = r[7:0];
        end
        for (int s = 0; s < N_SIMPLE_SLOTS; s++) begin
            r              = rand32();
            simple_data[s] = r[7:0];
            simple_uo[s]   = r[15:8];
        end
        m_gpio_out = '0;
        for (int p = 0; p < N_PINS; p++) begin
            m_fsel[p] = (p < 2) ? func_sel_t'(SLOT_UART) : func_sel_t'(SLOT_GPIO);
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset defaults
        read_check(user_addr(int'(SLOT_GPIO), GPIO_OUT_OFS));
        for (int p = 0; p < N_PINS; p++) begin
            read_check(user_addr(int'(SLOT_GPIO), fsel_ofs(p)));
        end

        // GPIO registers and input readback
        repeat (20) begin
            r = rand32();
            if (r[0]) begin
                bus_write(user_addr(int'(SLOT_GPIO), GPIO_OUT_OFS), rand32());
            end else begin
                bus_write(user_addr(int'(SLOT_GPIO), fsel_ofs(int'(r[3:1]))), rand32());
            end
        end
        read_check(user_addr(int'(SLOT_GPIO), GPIO_OUT_OFS));
        for (int p = 0; p < N_PINS; p++) begin
            read_check(user_addr(int'(SLOT_GPIO), fsel_ofs(p)));
        end
        r     = rand32();
        ui_in = r[7:0];
        read_check(user_addr(int'(SLOT_GPIO), GPIO_IN_OFS));
        read_check(user_addr(int'(SLOT_GPIO), 6'h08));

        // Pin routing
        repeat (10) begin
            for (int s = 0; s < N_USER_SLOTS; s++) begin
                r          = rand32();
                user_uo[s] = r[7:0];
            end
            for (int s = 0; s < N_SIMPLE_SLOTS; s++) begin
                r            = rand32();
                simple_uo[s] = r[7:0];
            end
            for (int p = 0; p < N_PINS; p++) begin
                bus_write(user_addr(int'(SLOT_GPIO), fsel_ofs(p)), rand32());
            end
            bus_write(user_addr(int'(SLOT_GPIO), GPIO_OUT_OFS), rand32());
            #1;
            check("o_uo_out", 32'(uo_out), 32'(model_pins()));
        end

        // Write strobes over the whole address space
        repeat (40) begin
            r = rand32();
            bus_write(r[10:0], rand32());
        end

        // Read capture from simple, GPIO and stalled user slots
        repeat (24) begin
            r = rand32();
            case (r[1:0])
                2'd0: begin
                    simple_data[r[7:4]] = r[23:16];
                    read_check({2'b10, r[8], r[7:4], r[3:0]});
                end
                2'd1: read_check(user_addr(int'(SLOT_GPIO), {1'b1, r[4:2], 2'b00}));
                default: stalled_read(2 + int'(r[15:8] % 8'd22));
            endcase
        end

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 n_checks, n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/peripheral_fabric.sv
module peripheral_fabric (
    input  logic                                                 clk,
    input  logic                                                 rst_n,

    // Core side
    input  bus_pkg::bus_req_t                                    i_req,
    input  bus_pkg::byte_t                                       i_ui_in,
    input  logic                                                 i_read_complete,
    output bus_pkg::word_t                                       o_data_out,
    output logic                                                 o_data_ready,

    // External slots
    input  bus_pkg::word_t [periph_map_pkg::N_USER_SLOTS-1:0]    i_user_data,
    input  logic [periph_map_pkg::N_USER_SLOTS-1:0]              i_user_ready,
    input  bus_pkg::byte_t [periph_map_pkg::N_SIMPLE_SLOTS-1:0]  i_simple_data,
    input  bus_pkg::byte_t [periph_map_pkg::N_USER_SLOTS-1:0]    i_user_uo,
    input  bus_pkg::byte_t [periph_map_pkg::N_SIMPLE_SLOTS-1:0]  i_simple_uo,
    output periph_map_pkg::user_onehot_t                         o_user_sel,
    output periph_map_pkg::simple_onehot_t                       o_simple_write,
    output bus_pkg::access_n_t                                   o_peri_read_n,

    // Output pins
    output bus_pkg::byte_t                                       o_uo_out
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    periph_sel_t                 sel;
    user_onehot_t                user_sel;
    logic                        gpio_write;

    word_t                       gpio_rdata;
    byte_t                       gpio_out;
    func_sel_t [N_PINS-1:0]      func_sel;

    // Slot arrays with the internal slots filled in
    word_t [N_USER_SLOTS-1:0]    user_data;
    logic  [N_USER_SLOTS-1:0]    user_ready;
    byte_t [N_USER_SLOTS-1:0]    user_uo;

    periph_addr_decode u_decode (
        .i_req          (i_req),
        .o_sel          (sel),
        .o_user_sel     (user_sel),
        .o_simple_write (o_simple_write)
    );

    assign o_user_sel = user_sel;

    // GPIO block sits in user slot 1
    assign gpio_write = user_sel[SLOT_GPIO] && (i_req.write_n != ACCESS_NONE);

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (sel),
        .i_write    (gpio_write),
        .i_wdata    (i_req.wdata[7:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    always_comb begin
        user_data  = i_user_data;
        user_ready = i_user_ready;
        user_uo    = i_user_uo;

        // Slot 0 is empty
        user_data[0]  = '0;
        user_ready[0] = 1'b0;
        user_uo[0]    = '0;

        // GPIO answers at once
        user_data[SLOT_GPIO]  = gpio_rdata;
        user_ready[SLOT_GPIO] = 1'b1;
        user_uo[SLOT_GPIO]    = gpio_out;
    end

    pin_out_mux u_pin_mux (
        .i_func_sel  (func_sel),
        .i_user_uo   (user_uo),
        .i_simple_uo (i_simple_uo),
        .o_uo_out    (o_uo_out)
    );

    read_data_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_sel           (sel),
        .i_read_n        (i_req.read_n),
        .i_write_n       (i_req.write_n),
        .i_user_data     (user_data),
        .i_user_ready    (user_ready),
        .i_simple_data   (i_simple_data),
        .i_read_complete (i_read_complete),
        .o_peri_read_n   (o_peri_read_n),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

endmodule

// File: verilog/read_data_capture.sv
module read_data_capture (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  periph_map_pkg::periph_sel_t                          i_sel,
    input  bus_pkg::access_n_t                                   i_read_n,
    input  bus_pkg::access_n_t                                   i_write_n,
    input  bus_pkg::word_t [periph_map_pkg::N_USER_SLOTS-1:0]    i_user_data,
    input  logic [periph_map_pkg::N_USER_SLOTS-1:0]              i_user_ready,
    input  bus_pkg::byte_t [periph_map_pkg::N_SIMPLE_SLOTS-1:0]  i_simple_data,
    input  logic                                                 i_read_complete,
    output bus_pkg::access_n_t                                   o_peri_read_n,
    output bus_pkg::word_t                                       o_data_out,
    output logic                                                 o_data_ready
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    word_t peri_data;
    logic  peri_ready;
    logic  read_req;
    logic  capture;
    word_t data_q;
    logic  hold_q;
    logic  ready_q;

    // Data and ready of the addressed slot
    always_comb begin
        if (i_sel.is_simple) begin
            peri_data  = word_t'(i_simple_data[i_sel.simple_slot]);
            peri_ready = 1'b1;
        end else begin
            peri_data  = i_user_data[i_sel.user_slot];
            peri_ready = i_user_ready[i_sel.user_slot];
        end
    end

    assign read_req = (i_read_n != ACCESS_NONE);
    assign capture  = read_req && peri_ready && (!hold_q || i_read_complete);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            // A new capture wins over the release in the same cycle
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= peri_data;
        end
    end

    // No repeat read towards the slot while the result is on the bus
    assign o_peri_read_n = ready_q ? ACCESS_NONE : i_read_n;

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_write_n != ACCESS_NONE);

endmodule

// File: verilog/pin_out_mux.sv
module pin_out_mux (
    input  periph_map_pkg::func_sel_t [periph_map_pkg::N_PINS-1:0]    i_func_sel,
    input  bus_pkg::byte_t [periph_map_pkg::N_USER_SLOTS-1:0]         i_user_uo,
    input  bus_pkg::byte_t [periph_map_pkg::N_SIMPLE_SLOTS-1:0]       i_simple_uo,
    output bus_pkg::byte_t                                            o_uo_out
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    for (genvar p = 0; p < N_PINS; p++) begin : g_pin
        user_slot_t   user_idx;
        simple_slot_t simple_idx;

        assign user_idx   = {i_func_sel[p][5], i_func_sel[p][3:0]};
        assign simple_idx = i_func_sel[p][3:0];

        // Each pin takes its own bit of the chosen slot's output byte
        always_comb begin
            o_uo_out[p] = 1'b0;
            if (i_func_sel[p][4]) begin
                o_uo_out[p] = i_simple_uo[simple_idx][p];
            end else if (user_idx < user_slot_t'(N_USER_SLOTS)) begin
                o_uo_out[p] = i_user_uo[user_idx][p];
            end
        end
    end

endmodule

// File: verilog/gpio_regs.sv
module gpio_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_map_pkg::periph_sel_t i_sel,
    input  logic                        i_write,
    input  bus_pkg::byte_t              i_wdata,
    input  bus_pkg::byte_t              i_ui_in,
    output bus_pkg::word_t              o_rdata,
    output bus_pkg::byte_t              o_gpio_out,
    output periph_map_pkg::func_sel_t [periph_map_pkg::N_PINS-1:0] o_func_sel
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    // Pins driven by the UART after reset
    localparam int UART_PINS = 2;

    byte_t                   gpio_out;
    func_sel_t [N_PINS-1:0]  func_sel;
    logic                    fsel_hit;
    logic [2:0]              fsel_idx;

    // Select words at 0x20, 0x24 .. 0x3c, one per pin
    assign fsel_hit = ((i_sel.offset & 6'h23) == GPIO_FSEL_BASE);
    assign fsel_idx = i_sel.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (i_write && (i_sel.offset == GPIO_OUT_OFS)) begin
            gpio_out <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < N_PINS; p++) begin
                if (p < UART_PINS) begin
                    func_sel[p] <= func_sel_t'(SLOT_UART);
                end else begin
                    func_sel[p] <= func_sel_t'(SLOT_GPIO);
                end
            end
        end else if (i_write && fsel_hit) begin
            func_sel[fsel_idx] <= i_wdata[5:0];
        end
    end

    // Readback, zero outside the defined offsets
    always_comb begin
        o_rdata = '0;
        if (i_sel.offset == GPIO_OUT_OFS) begin
            o_rdata = word_t'(gpio_out);
        end else if (i_sel.offset == GPIO_IN_OFS) begin
            o_rdata = word_t'(i_ui_in);
        end else if (fsel_hit) begin
            o_rdata = word_t'(func_sel[fsel_idx]);
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_func_sel = func_sel;

endmodule

// File: verilog/periph_addr_decode.sv
module periph_addr_decode (
    input  bus_pkg::bus_req_t              i_req,
    output periph_map_pkg::periph_sel_t    o_sel,
    output periph_map_pkg::user_onehot_t   o_user_sel,
    output periph_map_pkg::simple_onehot_t o_simple_write
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    periph_addr_t addr;
    logic         write_req;

    assign addr      = i_req.addr;
    assign write_req = (i_req.write_n != ACCESS_NONE);

    // Map the address onto a slot
    always_comb begin
        o_sel        = '0;
        o_sel.offset = addr[5:0];

        if (addr[10:9] == 2'b10) begin
            // Simple space, 16 bytes per slot
            o_sel.is_simple   = 1'b1;
            o_sel.simple_slot = addr[7:4];
        end else if (addr[10]) begin
            // Upper user slots 16..23
            o_sel.user_slot = {2'b10, addr[8:6]};
        end else begin
            o_sel.user_slot = {1'b0, addr[9:6]};
        end
    end

    // One-hot selects for the slots
    always_comb begin
        o_user_sel     = '0;
        o_simple_write = '0;

        if (o_sel.is_simple) begin
            // Simple slots only see a write strobe
            o_simple_write[o_sel.simple_slot] = write_req;
        end else begin
            o_user_sel[o_sel.user_slot] = 1'b1;
        end
    end

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

    // Core data bus widths
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Access size, active low; both bits high means no access
    typedef logic [1:0] access_n_t;

    localparam access_n_t ACCESS_BYTE = 2'b00;
    localparam access_n_t ACCESS_HALF = 2'b01;
    localparam access_n_t ACCESS_WORD = 2'b10;
    localparam access_n_t ACCESS_NONE = 2'b11;

    // One request from the core to the peripheral space
    typedef struct packed {
        periph_map_pkg::periph_addr_t addr;
        word_t                        wdata;
        access_n_t                    write_n;
        access_n_t                    read_n;
    } bus_req_t;

endpackage

// File: verilog/periph_map_pkg.sv
package periph_map_pkg;

    // Peripheral address, offset into the 2 KB peripheral window
    typedef logic [10:0] periph_addr_t;

    localparam int N_USER_SLOTS   = 24;
    localparam int N_SIMPLE_SLOTS = 16;
    localparam int N_PINS         = 8;

    // Slot indices and one-hot selects
    typedef logic [4:0]  user_slot_t;
    typedef logic [3:0]  simple_slot_t;
    typedef logic [23:0] user_onehot_t;
    typedef logic [15:0] simple_onehot_t;

    // Byte offset inside one user slot
    typedef logic [5:0] local_ofs_t;

    // Pin function select
    // Bit 4 picks the simple space, bit 5 is the high bit of a user slot
    typedef logic [5:0] func_sel_t;

    // Fixed slot assignments
    localparam user_slot_t SLOT_GPIO = 5'd1;
    localparam user_slot_t SLOT_UART = 5'd2;

    // GPIO register offsets
    localparam local_ofs_t GPIO_OUT_OFS   = 6'h00;
    localparam local_ofs_t GPIO_IN_OFS    = 6'h04;
    localparam local_ofs_t GPIO_FSEL_BASE = 6'h20;

    // Result of the address decode
    typedef struct packed {
        logic         is_simple;
        user_slot_t   user_slot;
        simple_slot_t simple_slot;
        local_ofs_t   offset;
    } periph_sel_t;

endpackage
